// ==== rtl/axi_read_master_defines.svh ====
`ifndef AXI_READ_MASTER_DEFINES_SVH
`define AXI_READ_MASTER_DEFINES_SVH

// Bus widths
`define ARM_ADDR_W          32
`define ARM_DATA_W          32
`define ARM_SIZE_W          16

// Beat and burst geometry
`define ARM_BEAT_BYTES      4
`define ARM_BEAT_LOG        2
`define ARM_BURST_BEATS     16
`define ARM_BURST_LOG       4
`define ARM_BURST_BYTES     (`ARM_BEAT_BYTES * `ARM_BURST_BEATS)
`define ARM_ADDR_MASK       (`ARM_BURST_BYTES - 1)

// Beat count minus one, and the burst count taken from its upper bits
`define ARM_LEN_W           (`ARM_SIZE_W - `ARM_BEAT_LOG)
`define ARM_BURST_CNT_W     (`ARM_LEN_W - `ARM_BURST_LOG)

// Outstanding limit, credit counter and FIFO sizing
`define ARM_MAX_OUTSTANDING 4
`define ARM_CREDIT_W        3
`define ARM_FIFO_DEPTH      (`ARM_BURST_BEATS * `ARM_MAX_OUTSTANDING)
`define ARM_FIFO_PTR_W      6

`endif

// ==== rtl/axi_read_master_pkg.sv ====
package axi_read_master_pkg;

  // Control FSM states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_RUN,
    ST_DONE
  } ctrl_state_e;

  // Selects the arlen of the burst on the AR channel
  typedef enum logic {
    BURST_FULL,
    BURST_FINAL
  } burst_kind_e;

endpackage

// ==== rtl/xfer_if.sv ====
`timescale 1ns/1ps
`include "axi_read_master_defines.svh"

interface xfer_if;

  // One-cycle pulse, plan fields below are valid while it is high
  logic                          load;
  // Start address, aligned down to a burst boundary
  logic [`ARM_ADDR_W-1:0]        base_addr;
  // Number of bursts minus one
  logic [`ARM_BURST_CNT_W-1:0]   num_bursts;
  // arlen of the final burst
  logic [`ARM_BURST_LOG-1:0]     final_len;
  // Pulses when the final AR is accepted
  logic                          ar_done;

  modport fsm (
    output load,
    output base_addr,
    output num_bursts,
    output final_len,
    input  ar_done
  );

  modport issuer (
    input  load,
    input  base_addr,
    input  num_bursts,
    input  final_len,
    output ar_done
  );

endinterface

// ==== rtl/burst_counter.sv ====
`timescale 1ns/1ps

module burst_counter #(
  parameter int unsigned      WIDTH = 4,
  parameter logic [WIDTH-1:0] INIT  = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic             incr,
  input  logic             decr,
  input  logic [WIDTH-1:0] load_value,
  output logic [WIDTH-1:0] count,
  output logic             is_zero
);

  // Load wins over counting
  // Simultaneous incr and decr leave the count unchanged
  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= INIT;
    end else if (load) begin
      count <= load_value;
    end else if (incr && !decr) begin
      count <= count + WIDTH'(1);
    end else if (decr && !incr) begin
      count <= count - WIDTH'(1);
    end
  end

  assign is_zero = (count == '0);

endmodule

// ==== rtl/xfer_ctrl_fsm.sv ====
`timescale 1ns/1ps
`include "axi_read_master_defines.svh"

module xfer_ctrl_fsm (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   ctrl_start,
  input  logic [`ARM_ADDR_W-1:0] ctrl_addr,
  input  logic [`ARM_SIZE_W-1:0] ctrl_size,
  input  logic                   r_last_beat,
  output logic                   ctrl_done,
  xfer_if.fsm                    plan
);

  axi_read_master_pkg::ctrl_state_e state;

  logic [`ARM_SIZE_W-1:0] size_m1;
  logic [`ARM_LEN_W-1:0]  beats_m1;
  logic                   ar_all_issued;
  logic                   r_final;

  //////////////////////////////////////////////////////////////////////
  // Request capture and burst plan
  //////////////////////////////////////////////////////////////////////

  // Beats minus one is (bytes - 1) / 4, which rounds up to whole words
  assign size_m1 = ctrl_size - `ARM_SIZE_W'(1);

  always_ff @(posedge aclk) begin
    if (state == axi_read_master_pkg::ST_IDLE && ctrl_start) begin
      plan.base_addr <= ctrl_addr & ~`ARM_ADDR_W'(`ARM_ADDR_MASK);
      beats_m1       <= size_m1[`ARM_SIZE_W-1:`ARM_BEAT_LOG];
    end
    // Upper bits count full bursts, low bits give the last arlen
    if (state == axi_read_master_pkg::ST_SETUP) begin
      plan.num_bursts <= beats_m1[`ARM_LEN_W-1:`ARM_BURST_LOG];
      plan.final_len  <= beats_m1[`ARM_BURST_LOG-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      state         <= axi_read_master_pkg::ST_IDLE;
      plan.load     <= 1'b0;
      ar_all_issued <= 1'b0;
      ctrl_done     <= 1'b0;
    end else begin
      // Load fires on entry to ST_RUN
      plan.load <= (state == axi_read_master_pkg::ST_SETUP);
      ctrl_done <= (state == axi_read_master_pkg::ST_DONE);
      if (plan.load) begin
        ar_all_issued <= 1'b0;
      end else if (plan.ar_done) begin
        ar_all_issued <= 1'b1;
      end
      case (state)
        axi_read_master_pkg::ST_IDLE: begin
          // Start is only sampled here
          if (ctrl_start) begin
            state <= axi_read_master_pkg::ST_SETUP;
          end
        end
        axi_read_master_pkg::ST_SETUP: state <= axi_read_master_pkg::ST_RUN;
        axi_read_master_pkg::ST_RUN: begin
          // Finished on the rlast of the final burst
          if (r_final && r_last_beat && ar_all_issued) begin
            state <= axi_read_master_pkg::ST_DONE;
          end
        end
        default: state <= axi_read_master_pkg::ST_IDLE;
      endcase
    end
  end

  // Bursts still waiting for their rlast, minus one
  burst_counter #(
    .WIDTH (`ARM_BURST_CNT_W),
    .INIT  ('0)
  ) u_r_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (plan.load),
    .incr       (1'b0),
    .decr       (r_last_beat),
    .load_value (plan.num_bursts),
    .count      (),
    .is_zero    (r_final)
  );

endmodule

// ==== rtl/ar_issue.sv ====
`timescale 1ns/1ps
`include "axi_read_master_defines.svh"

module ar_issue (
  input  logic                   aclk,
  input  logic                   areset,
  xfer_if.issuer                 plan,
  input  logic                   burst_retired,
  output logic                   arvalid,
  input  logic                   arready,
  output logic [`ARM_ADDR_W-1:0] araddr,
  output logic [7:0]             arlen
);

  axi_read_master_pkg::burst_kind_e kind;

  logic ar_xfer;
  logic active;
  logic final_burst;
  logic no_credit;

  assign ar_xfer = arvalid && arready;

  // Active from load until the final AR is taken
  always_ff @(posedge aclk) begin
    if (areset) begin
      active <= 1'b0;
    end else if (plan.load) begin
      active <= 1'b1;
    end else if (plan.ar_done) begin
      active <= 1'b0;
    end
  end

  // Drop after acceptance, rise again next cycle if work and credit remain
  always_ff @(posedge aclk) begin
    if (areset) begin
      arvalid <= 1'b0;
    end else if (!arvalid && active && !no_credit) begin
      arvalid <= 1'b1;
    end else if (arready) begin
      arvalid <= 1'b0;
    end
  end

  // Linear address, one full burst per step
  always_ff @(posedge aclk) begin
    if (plan.load) begin
      araddr <= plan.base_addr;
    end else if (ar_xfer) begin
      araddr <= araddr + `ARM_ADDR_W'(`ARM_BURST_BYTES);
    end
  end

  assign kind = final_burst ? axi_read_master_pkg::BURST_FINAL
                            : axi_read_master_pkg::BURST_FULL;
  assign arlen = (kind == axi_read_master_pkg::BURST_FINAL)
               ? {{(8 - `ARM_BURST_LOG){1'b0}}, plan.final_len}
               : 8'(`ARM_BURST_BEATS - 1);

  assign plan.ar_done = ar_xfer && final_burst;

  // Bursts left to issue, zero marks the final one
  burst_counter #(
    .WIDTH (`ARM_BURST_CNT_W),
    .INIT  ('0)
  ) u_ar_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (plan.load),
    .incr       (1'b0),
    .decr       (ar_xfer),
    .load_value (plan.num_bursts),
    .count      (),
    .is_zero    (final_burst)
  );

  // Free slots for outstanding bursts
  // taken on AR accept, given back when a burst leaves the stream
  burst_counter #(
    .WIDTH (`ARM_CREDIT_W),
    .INIT  (`ARM_CREDIT_W'(`ARM_MAX_OUTSTANDING))
  ) u_credit_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (burst_retired),
    .decr       (ar_xfer),
    .load_value ('0),
    .count      (),
    .is_zero    (no_credit)
  );

endmodule

// ==== rtl/read_data_fifo.sv ====
`timescale 1ns/1ps
`include "axi_read_master_defines.svh"

module read_data_fifo (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   wr_valid,
  input  logic                   wr_last,
  input  logic [`ARM_DATA_W-1:0] wr_data,
  output logic                   rd_valid,
  input  logic                   rd_ready,
  output logic [`ARM_DATA_W-1:0] rd_data,
  output logic                   rd_last
);

  // Each entry holds last in the top bit and the data below
  logic [`ARM_DATA_W:0]      mem [`ARM_FIFO_DEPTH];
  logic [`ARM_FIFO_PTR_W-1:0] wr_ptr;
  logic [`ARM_FIFO_PTR_W-1:0] rd_ptr;
  // Entries in memory, the output register not included
  logic [`ARM_FIFO_PTR_W:0]   count;

  logic out_free;
  logic mem_pop;
  logic mem_push;

  assign out_free = !rd_valid || rd_ready;
  assign mem_pop  = out_free && (count != '0);
  // Write bypasses memory when it is empty and the output is free
  assign mem_push = wr_valid && !(out_free && (count == '0));

  always_ff @(posedge aclk) begin
    if (mem_push) begin
      mem[wr_ptr] <= {wr_last, wr_data};
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      rd_valid <= 1'b0;
    end else begin
      wr_ptr   <= wr_ptr + `ARM_FIFO_PTR_W'(mem_push);
      rd_ptr   <= rd_ptr + `ARM_FIFO_PTR_W'(mem_pop);
      count    <= count + (`ARM_FIFO_PTR_W+1)'(mem_push) - (`ARM_FIFO_PTR_W+1)'(mem_pop);
      if (out_free) begin
        rd_valid <= mem_pop || wr_valid;
      end
    end
  end

  // Registered output stage, oldest entry first
  always_ff @(posedge aclk) begin
    if (mem_pop) begin
      {rd_last, rd_data} <= mem[rd_ptr];
    end else if (out_free && wr_valid) begin
      {rd_last, rd_data} <= {wr_last, wr_data};
    end
  end

endmodule

// ==== rtl/axi_read_master.sv ====
`timescale 1ns/1ps
`include "axi_read_master_defines.svh"

module axi_read_master (
  input  logic                   aclk,
  input  logic                   areset,
  // Control, sampled on the start pulse
  input  logic                   ctrl_start,
  input  logic [`ARM_ADDR_W-1:0] ctrl_addr,
  input  logic [`ARM_SIZE_W-1:0] ctrl_size,
  output logic                   ctrl_done,
  // AXI4 read address channel
  output logic                   m_axi_arvalid,
  input  logic                   m_axi_arready,
  output logic [`ARM_ADDR_W-1:0] m_axi_araddr,
  output logic [7:0]             m_axi_arlen,
  // AXI4 read data channel
  input  logic                   m_axi_rvalid,
  output logic                   m_axi_rready,
  input  logic [`ARM_DATA_W-1:0] m_axi_rdata,
  input  logic                   m_axi_rlast,
  // AXI4-Stream output
  output logic                   m_axis_tvalid,
  input  logic                   m_axis_tready,
  output logic [`ARM_DATA_W-1:0] m_axis_tdata,
  output logic                   m_axis_tlast
);

  logic r_beat;
  logic r_last_beat;
  logic burst_retired;

  xfer_if plan ();

  // FIFO always has room for every outstanding burst
  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axi_rready <= 1'b0;
    end else begin
      m_axi_rready <= 1'b1;
    end
  end

  assign r_beat        = m_axi_rvalid && m_axi_rready;
  assign r_last_beat   = r_beat && m_axi_rlast;
  assign burst_retired = m_axis_tvalid && m_axis_tready && m_axis_tlast;

  xfer_ctrl_fsm u_ctrl (
    .aclk        (aclk),
    .areset      (areset),
    .ctrl_start  (ctrl_start),
    .ctrl_addr   (ctrl_addr),
    .ctrl_size   (ctrl_size),
    .r_last_beat (r_last_beat),
    .ctrl_done   (ctrl_done),
    .plan        (plan.fsm)
  );

  ar_issue u_ar (
    .aclk          (aclk),
    .areset        (areset),
    .plan          (plan.issuer),
    .burst_retired (burst_retired),
    .arvalid       (m_axi_arvalid),
    .arready       (m_axi_arready),
    .araddr        (m_axi_araddr),
    .arlen         (m_axi_arlen)
  );

  read_data_fifo u_fifo (
    .aclk     (aclk),
    .areset   (areset),
    .wr_valid (r_beat),
    .wr_last  (m_axi_rlast),
    .wr_data  (m_axi_rdata),
    .rd_valid (m_axis_tvalid),
    .rd_ready (m_axis_tready),
    .rd_data  (m_axis_tdata),
    .rd_last  (m_axis_tlast)
  );

endmodule

// ==== bench/axi_read_master_sva.sv ====
`timescale 1ns/1ps
`include "axi_read_master_defines.svh"

module axi_read_master_sva (
  input logic                   aclk,
  input logic                   areset,
  input logic                   m_axi_arvalid,
  input logic                   m_axi_arready,
  input logic [`ARM_ADDR_W-1:0] m_axi_araddr,
  input logic [7:0]             m_axi_arlen,
  input logic                   m_axi_rready,
  input logic                   m_axis_tvalid,
  input logic                   m_axis_tready,
  input logic [`ARM_DATA_W-1:0] m_axis_tdata,
  input logic                   m_axis_tlast
);

  // Failed assertions, read by the testbench for its verdict
  int assert_failures = 0;
  // ARs accepted whose burst has not yet left the stream
  int outstanding;

  always @(posedge aclk) begin
    if (areset) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(m_axi_arvalid && m_axi_arready)
                   - int'(m_axis_tvalid && m_axis_tready && m_axis_tlast);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Handshake and credit properties
  //////////////////////////////////////////////////////////////////////

  // AR request holds with a stable payload until accepted
  ar_held: assert property (@(posedge aclk) disable iff (areset)
    m_axi_arvalid && !m_axi_arready |=>
      m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arlen))
    else begin
      assert_failures++;
      $error("AR request dropped or changed before acceptance");
    end

  // Stream beat holds in place under back-pressure
  stream_held: assert property (@(posedge aclk) disable iff (areset)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
    else begin
      assert_failures++;
      $error("Stream beat dropped or changed before acceptance");
    end

  // R channel never refuses a beat once out of reset
  rready_on: assert property (@(posedge aclk) disable iff (areset)
    !areset |=> m_axi_rready)
    else begin
      assert_failures++;
      $error("rready low after reset");
    end

  // Never more bursts in flight than the FIFO can hold
  credit_limit: assert property (@(posedge aclk) disable iff (areset)
    outstanding <= `ARM_MAX_OUTSTANDING)
    else begin
      assert_failures++;
      $error("More than the allowed number of bursts outstanding");
    end

endmodule

// ==== bench/tb_axi_read_master.sv ====
`timescale 1ns/1ps
`include "axi_read_master_defines.svh"

module tb_axi_read_master;

  // About 570 beats in all, up to 8 cycles each under back-pressure,
  // plus AR and reset time, with a wide margin
  localparam int WATCHDOG_CYCLES = 20000;
  // Quiet cycles after the last beat, catches stray ARs, beats or done pulses
  localparam int SETTLE_CYCLES   = 24;

  logic                   aclk = 1'b0;
  logic                   areset;
  logic                   ctrl_start;
  logic [`ARM_ADDR_W-1:0] ctrl_addr;
  logic [`ARM_SIZE_W-1:0] ctrl_size;
  logic                   ctrl_done;
  logic                   m_axi_arvalid;
  logic                   m_axi_arready = 1'b0;
  logic [`ARM_ADDR_W-1:0] m_axi_araddr;
  logic [7:0]             m_axi_arlen;
  logic                   m_axi_rvalid  = 1'b0;
  logic                   m_axi_rready;
  logic [`ARM_DATA_W-1:0] m_axi_rdata   = '0;
  logic                   m_axi_rlast   = 1'b0;
  logic                   m_axis_tvalid;
  logic                   m_axis_tready = 1'b0;
  logic [`ARM_DATA_W-1:0] m_axis_tdata;
  logic                   m_axis_tlast;

  integer seed = 32'h3849_53af;
  int     errors = 0;
  int     checks = 0;
  int     total_errors;
  // Mostly-low tready for the back-pressure test
  bit     sparse_tready = 1'b0;

  // Slave side, bursts accepted on AR that still owe R beats
  logic [`ARM_ADDR_W-1:0] pend_addr [$];
  logic [7:0]             pend_len [$];
  int                     beat_idx;

  // What the DUT did during the current test
  logic [`ARM_ADDR_W-1:0] ar_addr_log [$];
  logic [7:0]             ar_len_log [$];
  logic [`ARM_DATA_W-1:0] beat_data_log [$];
  logic                   beat_last_log [$];
  int                     done_cycles;

  always #10 aclk = ~aclk;

  axi_read_master DUT (.*);

  bind axi_read_master axi_read_master_sva u_sva (
    .aclk          (aclk),
    .areset        (areset),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arlen   (m_axi_arlen),
    .m_axi_rready  (m_axi_rready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast)
  );

  //////////////////////////////////////////////////////////////////////
  // Memory slave and stream sink
  //////////////////////////////////////////////////////////////////////

  // One block so the random draws come in a fixed order
  always @(posedge aclk) begin
    if (areset) begin
      m_axi_arready <= 1'b0;
      m_axi_rvalid  <= 1'b0;
      m_axis_tready <= 1'b0;
      beat_idx = 0;
    end else begin
      if (m_axi_arvalid && m_axi_arready) begin
        ar_addr_log.push_back(m_axi_araddr);
        ar_len_log.push_back(m_axi_arlen);
        pend_addr.push_back(m_axi_araddr);
        pend_len.push_back(m_axi_arlen);
      end
      m_axi_arready <= (($random(seed) & 3) != 0);
      // Step through the current burst, drop it on rlast
      if (m_axi_rvalid && m_axi_rready) begin
        if (m_axi_rlast) begin
          void'(pend_addr.pop_front());
          void'(pend_len.pop_front());
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end
      // Next beat once the bus is free, random gaps in between
      if (!m_axi_rvalid || m_axi_rready) begin
        if (pend_addr.size() != 0 && ($random(seed) & 3) != 0) begin
          m_axi_rvalid <= 1'b1;
          m_axi_rdata  <= pend_addr[0] + 32'(4 * beat_idx);
          m_axi_rlast  <= (beat_idx == int'(pend_len[0]));
        end else begin
          m_axi_rvalid <= 1'b0;
        end
      end
      // Sink logs every accepted stream beat
      if (m_axis_tvalid && m_axis_tready) begin
        beat_data_log.push_back(m_axis_tdata);
        beat_last_log.push_back(m_axis_tlast);
      end
      if (sparse_tready) begin
        m_axis_tready <= (($random(seed) & 7) == 0);
      end else begin
        m_axis_tready <= (($random(seed) & 3) != 0);
      end
      if (ctrl_done) begin
        done_cycles++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // Bytes rounded up to whole data words
  function automatic int word_count(input int size);
    return (size + `ARM_BEAT_BYTES - 1) / `ARM_BEAT_BYTES;
  endfunction

  task automatic start_transfer(input logic [31:0] addr, input int size);
    @(negedge aclk);
    ar_addr_log.delete();
    ar_len_log.delete();
    beat_data_log.delete();
    beat_last_log.delete();
    done_cycles = 0;
    @(posedge aclk);
    ctrl_addr  <= addr;
    ctrl_size  <= size[15:0];
    ctrl_start <= 1'b1;
    @(posedge aclk);
    ctrl_start <= 1'b0;
  endtask

  // Done comes before the stream has drained, so wait for both
  task automatic wait_for_completion(input int size);
    @(negedge aclk);
    while (done_cycles == 0) begin
      @(negedge aclk);
    end
    while (beat_data_log.size() < word_count(size)) begin
      @(negedge aclk);
    end
    repeat (SETTLE_CYCLES) @(negedge aclk);
  endtask

  task automatic check_transfer(input logic [31:0] addr, input int size);
    int          beats;
    int          bursts;
    int          n;
    int          k;
    logic [31:0] base;
    beats  = word_count(size);
    bursts = (beats + `ARM_BURST_BEATS - 1) / `ARM_BURST_BEATS;
    // Start address aligned down to a burst boundary
    base   = addr - (addr % `ARM_BURST_BYTES);
    check_value("AR count", ar_addr_log.size(), bursts);
    n = (ar_addr_log.size() < bursts) ? ar_addr_log.size() : bursts;
    for (k = 0; k < n; k++) begin
      check_value($sformatf("m_axi_araddr[%0d]", k), ar_addr_log[k],
                  base + 32'(k * `ARM_BURST_BYTES));
      check_value($sformatf("m_axi_arlen[%0d]", k), ar_len_log[k],
                  (k == bursts - 1) ? beats - k * `ARM_BURST_BEATS - 1
                                    : `ARM_BURST_BEATS - 1);
    end
    check_value("stream beat count", beat_data_log.size(), beats);
    n = (beat_data_log.size() < beats) ? beat_data_log.size() : beats;
    for (k = 0; k < n; k++) begin
      check_value($sformatf("m_axis_tdata[%0d]", k), beat_data_log[k],
                  base + 32'(k * `ARM_BEAT_BYTES));
      check_value($sformatf("m_axis_tlast[%0d]", k), beat_last_log[k],
                  (k % `ARM_BURST_BEATS == `ARM_BURST_BEATS - 1) || (k == beats - 1));
    end
    check_value("ctrl_done high cycles", done_cycles, 1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic single_short_transfer();
    start_transfer(32'h100, 40);
    wait_for_completion(40);
    check_transfer(32'h100, 40);
  endtask

  task automatic rounding_and_alignment();
    start_transfer(32'h1234, 37);
    wait_for_completion(37);
    check_transfer(32'h1234, 37);
  endtask

  task automatic multi_burst_transfer();
    start_transfer(32'h4000, 1000);
    wait_for_completion(1000);
    check_transfer(32'h4000, 1000);
  endtask

  task automatic stream_back_pressure();
    sparse_tready = 1'b1;
    start_transfer(32'h4000, 1000);
    wait_for_completion(1000);
    check_transfer(32'h4000, 1000);
    sparse_tready = 1'b0;
  endtask

  // Second request arrives mid-transfer and must leave no trace
  task automatic start_ignored_while_busy();
    start_transfer(32'h8000, 200);
    repeat (8) @(posedge aclk);
    ctrl_addr  <= 32'h9040;
    ctrl_size  <= 16'd400;
    ctrl_start <= 1'b1;
    @(posedge aclk);
    ctrl_start <= 1'b0;
    wait_for_completion(200);
    check_transfer(32'h8000, 200);
  endtask

  initial begin
    areset     = 1'b1;
    ctrl_start = 1'b0;
    ctrl_addr  = '0;
    ctrl_size  = '0;
    repeat (16) @(posedge aclk);
    areset <= 1'b0;
    repeat (4) @(posedge aclk);
    single_short_transfer();
    rounding_and_alignment();
    multi_burst_transfer();
    stream_back_pressure();
    start_ignored_while_busy();
    total_errors = errors + DUT.u_sva.assert_failures;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, DUT.u_sva.assert_failures);
    if (total_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge aclk);
    $display("Timeout after %0d cycles, a transfer never completed", WATCHDOG_CYCLES);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/axi_read_master_pkg.sv
rtl/xfer_if.sv
rtl/burst_counter.sv
rtl/xfer_ctrl_fsm.sv
rtl/ar_issue.sv
rtl/read_data_fifo.sv
rtl/axi_read_master.sv
bench/axi_read_master_sva.sv
bench/tb_axi_read_master.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_axi_read_master
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qxF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
